// ==== common/rob_pkg.sv ====
/*
 * Shared definitions for the in-order retirement block: data widths,
 * instruction kinds and the result word that a completed entry holds
 */
package rob_pkg;

    // Width of register data, instruction addresses and branch targets
    localparam int XLEN = 32;

    // Architectural register file size and its index width
    localparam int NREG    = 32;
    localparam int RADDR_W = 5;

    // Kind of instruction held in a ROB entry
    // Only branches change how the entry retires
    typedef enum logic [1:0] {
        OP_ALU    = 2'd0,
        OP_LOAD   = 2'd1,
        OP_STORE  = 2'd2,
        OP_BRANCH = 2'd3
    } rob_op_t;

    // The word written back on the CDB at completion
    // A taken branch carries its redirect target, everything else
    // carries the value for its destination register
    typedef union packed {
        logic [XLEN-1:0] data;
        logic [XLEN-1:0] target;
    } rob_result_u;

endpackage

// ==== rob/reorder_buffer.sv ====
/*
 * Reorder buffer: allocates entries at the tail, completes them from the CDB,
 * retires the oldest done entry each cycle and resolves dispatch operands
 */
module reorder_buffer import rob_pkg::*; #(
    parameter int ROB_DEPTH = 16,
    parameter int TAG_W     = 4
) (
    input  logic               clk,
    input  logic               n_rst,
    input  logic               alloc_en,
    input  logic               flush,
    input  rob_op_t            disp_op,
    input  logic [RADDR_W-1:0] disp_rdest,
    input  logic [XLEN-1:0]    disp_iaddr,
    output logic [TAG_W-1:0]   disp_tag,
    input  logic               cdb_valid,
    input  logic [TAG_W-1:0]   cdb_tag,
    input  logic [XLEN-1:0]    cdb_data,
    input  logic               cdb_taken,
    input  logic               map_busy0,
    input  logic               map_busy1,
    input  logic [TAG_W-1:0]   map_tag0,
    input  logic [TAG_W-1:0]   map_tag1,
    input  logic [XLEN-1:0]    map_data0,
    input  logic [XLEN-1:0]    map_data1,
    output logic               src_rdy0,
    output logic               src_rdy1,
    output logic [TAG_W-1:0]   src_tag0,
    output logic [TAG_W-1:0]   src_tag1,
    output logic [XLEN-1:0]    src_data0,
    output logic [XLEN-1:0]    src_data1,
    output logic               retire_en,
    output logic               retire_valid,
    output logic [RADDR_W-1:0] retire_rdest,
    output logic [XLEN-1:0]    retire_data,
    output logic [TAG_W-1:0]   retire_tag,
    output logic               head_redirect,
    output logic [XLEN-1:0]    redirect_addr
);

    // Pointers wrap on their own since the depth is a power of two
    logic [TAG_W-1:0]   head;
    logic [TAG_W-1:0]   tail;

    // Entry state, split per field so each write port touches only its own fields
    logic               ent_valid  [ROB_DEPTH];
    logic               ent_done   [ROB_DEPTH];
    logic               ent_branch [ROB_DEPTH];
    rob_op_t            ent_op     [ROB_DEPTH];
    logic [RADDR_W-1:0] ent_rdest  [ROB_DEPTH];
    logic [XLEN-1:0]    ent_iaddr  [ROB_DEPTH];
    rob_result_u        ent_result [ROB_DEPTH];

    logic               head_is_br;

    // Operand priority is committed data, then a matching CDB broadcast,
    // then whatever the producer's entry holds
    // Returns the ready bit on top of the data word
    function automatic logic [XLEN:0] resolve(input logic             busy,
                                              input logic [TAG_W-1:0] tag,
                                              input logic [XLEN-1:0]  data);
        if (!busy) begin
            return {1'b1, data};
        end else if (cdb_valid && (cdb_tag == tag)) begin
            return {1'b1, cdb_data};
        end else begin
            return {ent_done[tag], ent_result[tag].data};
        end
    endfunction

    always_comb begin
        {src_rdy0, src_data0} = resolve(map_busy0, map_tag0, map_data0);
        {src_rdy1, src_data1} = resolve(map_busy1, map_tag1, map_data1);
    end

    // The producer tag passes through unchanged and only matters when not ready
    assign src_tag0 = map_tag0;
    assign src_tag1 = map_tag1;

    assign disp_tag   = tail;
    assign retire_tag = head;

    // The head retires as soon as it is done, one entry per cycle
    assign head_is_br    = (ent_op[head] == OP_BRANCH);
    assign retire_en     = ent_valid[head] && ent_done[head];
    assign retire_valid  = retire_en && !head_is_br;
    assign head_redirect = retire_en && head_is_br && ent_branch[head];
    assign retire_rdest  = ent_rdest[head];
    assign retire_data   = ent_result[head].data;
    assign redirect_addr = ent_result[head].target;

    always_ff @(posedge clk or negedge n_rst) begin
        if (!n_rst) begin
            head <= '0;
            tail <= '0;
        end else if (flush) begin
            head <= '0;
            tail <= '0;
        end else begin
            if (retire_en) begin
                head <= head + 1'b1;
            end
            if (alloc_en) begin
                tail <= tail + 1'b1;
            end
        end
    end

    // A flush squashes every entry, younger ones included
    always_ff @(posedge clk or negedge n_rst) begin
        if (!n_rst) begin
            for (int i = 0; i < ROB_DEPTH; i++) begin
                ent_valid[i] <= 1'b0;
            end
        end else if (flush) begin
            for (int i = 0; i < ROB_DEPTH; i++) begin
                ent_valid[i] <= 1'b0;
            end
        end else begin
            if (retire_en) begin
                ent_valid[head] <= 1'b0;
            end
            if (alloc_en) begin
                ent_valid[tail] <= 1'b1;
            end
        end
    end

    // Allocation and completion never address the same entry in one cycle,
    // since the CDB only carries tags of entries already in flight
    always_ff @(posedge clk or negedge n_rst) begin
        if (!n_rst) begin
            for (int i = 0; i < ROB_DEPTH; i++) begin
                ent_done[i] <= 1'b0;
            end
        end else begin
            if (alloc_en) begin
                ent_done[tail] <= 1'b0;
            end
            if (cdb_valid && ent_valid[cdb_tag]) begin
                ent_done[cdb_tag] <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (alloc_en) begin
            ent_op[tail]    <= disp_op;
            ent_rdest[tail] <= disp_rdest;
            ent_iaddr[tail] <= disp_iaddr;
        end
        // The taken flag selects how the stored word is read at retire
        if (cdb_valid) begin
            ent_branch[cdb_tag] <= cdb_taken;
            ent_result[cdb_tag] <= cdb_data;
        end
    end

    // Results may only come back for instructions that are still in flight
    cdb_tag_live: assert property (@(posedge clk) disable iff (!n_rst)
        cdb_valid |-> ent_valid[cdb_tag]);

    // A branch that redirects to itself would hang the machine
    no_self_redirect: assert property (@(posedge clk) disable iff (!n_rst)
        head_redirect |-> (redirect_addr != ent_iaddr[head]));

endmodule

// ==== hw/register_map.sv ====
/*
 * Architectural register map: committed values, newest producer tag and
 * busy bit per register, with two combinational lookup ports
 */
module register_map import rob_pkg::*; #(
    parameter int TAG_W = 4
) (
    input  logic               clk,
    input  logic               n_rst,
    input  logic               alloc_en,
    input  logic [RADDR_W-1:0] disp_rdest,
    input  logic [TAG_W-1:0]   disp_tag,
    input  logic               retire_valid,
    input  logic [RADDR_W-1:0] retire_rdest,
    input  logic [XLEN-1:0]    retire_data,
    input  logic [TAG_W-1:0]   retire_tag,
    input  logic               flush,
    input  logic [RADDR_W-1:0] disp_rsrc0,
    input  logic [RADDR_W-1:0] disp_rsrc1,
    output logic               map_busy0,
    output logic               map_busy1,
    output logic [TAG_W-1:0]   map_tag0,
    output logic [TAG_W-1:0]   map_tag1,
    output logic [XLEN-1:0]    map_data0,
    output logic [XLEN-1:0]    map_data1
);

    logic [XLEN-1:0]  regs [NREG];
    logic [TAG_W-1:0] tags [NREG];
    logic [NREG-1:0]  busy;

    // Committed values and producer tags
    // Register 0 is never written, so it keeps reading zero
    always_ff @(posedge clk or negedge n_rst) begin
        if (!n_rst) begin
            for (int i = 0; i < NREG; i++) begin
                regs[i] <= '0;
                tags[i] <= '0;
            end
        end else begin
            if (retire_valid && (retire_rdest != '0)) begin
                regs[retire_rdest] <= retire_data;
            end
            if (alloc_en && (disp_rdest != '0)) begin
                tags[disp_rdest] <= disp_tag;
            end
        end
    end

    // A retire only frees the register if no younger producer took it over
    // The allocation comes last so it wins when both hit one register
    always_ff @(posedge clk or negedge n_rst) begin
        if (!n_rst) begin
            busy <= '0;
        end else if (flush) begin
            busy <= '0;
        end else begin
            if (retire_valid && (tags[retire_rdest] == retire_tag)) begin
                busy[retire_rdest] <= 1'b0;
            end
            if (alloc_en && (disp_rdest != '0)) begin
                busy[disp_rdest] <= 1'b1;
            end
        end
    end

    // Lookups see the state before this cycle's updates
    assign map_busy0 = busy[disp_rsrc0];
    assign map_busy1 = busy[disp_rsrc1];
    assign map_tag0  = tags[disp_rsrc0];
    assign map_tag1  = tags[disp_rsrc1];
    assign map_data0 = regs[disp_rsrc0];
    assign map_data1 = regs[disp_rsrc1];

endmodule

// ==== hw/cdb_arbiter.sv ====
/*
 * CDB arbiter: fixed-priority merge of two execution result ports
 * onto the common data bus, with ex0 always winning
 */
module cdb_arbiter import rob_pkg::*; #(
    parameter int TAG_W = 4
) (
    input  logic             clk,
    input  logic             n_rst,
    input  logic             ex0_valid,
    input  logic [TAG_W-1:0] ex0_tag,
    input  logic [XLEN-1:0]  ex0_data,
    input  logic             ex0_taken,
    output logic             ex0_ready,
    input  logic             ex1_valid,
    input  logic [TAG_W-1:0] ex1_tag,
    input  logic [XLEN-1:0]  ex1_data,
    input  logic             ex1_taken,
    output logic             ex1_ready,
    output logic             cdb_valid,
    output logic [TAG_W-1:0] cdb_tag,
    output logic [XLEN-1:0]  cdb_data,
    output logic             cdb_taken
);

    logic grant0;
    logic grant1;

    // The bus takes one result per cycle and never stalls, so ex0 is always accepted
    assign grant0    = ex0_valid;
    assign grant1    = ex1_valid && !ex0_valid;
    assign ex0_ready = 1'b1;
    assign ex1_ready = !ex0_valid;

    assign cdb_valid = grant0 || grant1;
    assign cdb_tag   = grant0 ? ex0_tag   : ex1_tag;
    assign cdb_data  = grant0 ? ex0_data  : ex1_data;
    assign cdb_taken = grant0 ? ex0_taken : ex1_taken;

    bus_one_grant: assert property (@(posedge clk) disable iff (!n_rst)
        cdb_valid |-> $onehot({grant0, grant1}));

    // A stalled ex1 result has to wait unchanged for its turn
    ex1_hold: assert property (@(posedge clk) disable iff (!n_rst)
        (ex1_valid && !ex1_ready) |=> (ex1_valid && $stable(ex1_tag) && $stable(ex1_data)));

endmodule

// ==== hw/dispatch_ctrl.sv ====
/*
 * Dispatch control: owns ROB occupancy, accepts dispatches while there is
 * room and turns a redirect at the head into a machine-wide flush
 */
module dispatch_ctrl #(
    parameter int ROB_DEPTH = 16,
    parameter int TAG_W     = 4
) (
    input  logic clk,
    input  logic n_rst,
    input  logic disp_valid,
    input  logic retire_en,
    input  logic head_redirect,
    output logic disp_ready,
    output logic alloc_en,
    output logic flush
);

    // One extra bit so a full buffer is distinct from an empty one
    logic [TAG_W:0] count;

    // The flush lasts exactly the cycle the taken branch sits at the head
    assign flush = head_redirect;

    // Nothing enters while the machine is being squashed
    assign disp_ready = (count < ROB_DEPTH) && !flush;
    assign alloc_en   = disp_valid && disp_ready;

    always_ff @(posedge clk or negedge n_rst) begin
        if (!n_rst) begin
            count <= '0;
        end else if (flush) begin
            count <= '0;
        end else begin
            // A dispatch and a retire in one cycle cancel out
            case ({alloc_en, retire_en})
                2'b10: count <= count + 1'b1;
                2'b01: count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    count_in_range: assert property (@(posedge clk) disable iff (!n_rst)
        count <= ROB_DEPTH);

    // The ROB head and this counter must agree on whether anything is in flight
    retire_needs_entry: assert property (@(posedge clk) disable iff (!n_rst)
        retire_en |-> (count != '0));

endmodule

// ==== hw/ooo_retire_top.sv ====
/*
 * Top level of the retirement core: dispatch control, reorder buffer,
 * register map and CDB arbiter
 */
module ooo_retire_top import rob_pkg::*; #(
    parameter int ROB_DEPTH = 16,
    parameter int TAG_W     = $clog2(ROB_DEPTH)
) (
    input  logic               clk,
    input  logic               n_rst,
    input  logic               disp_valid,
    output logic               disp_ready,
    input  rob_op_t            disp_op,
    input  logic [RADDR_W-1:0] disp_rdest,
    input  logic [RADDR_W-1:0] disp_rsrc0,
    input  logic [RADDR_W-1:0] disp_rsrc1,
    input  logic [XLEN-1:0]    disp_iaddr,
    output logic [TAG_W-1:0]   disp_tag,
    output logic               src_rdy0,
    output logic               src_rdy1,
    output logic [TAG_W-1:0]   src_tag0,
    output logic [TAG_W-1:0]   src_tag1,
    output logic [XLEN-1:0]    src_data0,
    output logic [XLEN-1:0]    src_data1,
    input  logic               ex0_valid,
    output logic               ex0_ready,
    input  logic [TAG_W-1:0]   ex0_tag,
    input  logic [XLEN-1:0]    ex0_data,
    input  logic               ex0_taken,
    input  logic               ex1_valid,
    output logic               ex1_ready,
    input  logic [TAG_W-1:0]   ex1_tag,
    input  logic [XLEN-1:0]    ex1_data,
    input  logic               ex1_taken,
    output logic               retire_valid,
    output logic [RADDR_W-1:0] retire_rdest,
    output logic [XLEN-1:0]    retire_data,
    output logic               redirect,
    output logic [XLEN-1:0]    redirect_addr
);

    logic               alloc_en;
    logic               flush;
    logic               retire_en;
    logic               head_redirect;
    logic [TAG_W-1:0]   retire_tag;
    logic               cdb_valid;
    logic [TAG_W-1:0]   cdb_tag;
    logic [XLEN-1:0]    cdb_data;
    logic               cdb_taken;
    logic               map_busy0;
    logic               map_busy1;
    logic [TAG_W-1:0]   map_tag0;
    logic [TAG_W-1:0]   map_tag1;
    logic [XLEN-1:0]    map_data0;
    logic [XLEN-1:0]    map_data1;

    // The outside sees the flush pulse as the redirect strobe
    assign redirect = flush;

    dispatch_ctrl #(.ROB_DEPTH(ROB_DEPTH), .TAG_W(TAG_W)) ctrl0 (
        .clk(clk), .n_rst(n_rst),
        .disp_valid(disp_valid), .retire_en(retire_en), .head_redirect(head_redirect),
        .disp_ready(disp_ready), .alloc_en(alloc_en), .flush(flush)
    );

    reorder_buffer #(.ROB_DEPTH(ROB_DEPTH), .TAG_W(TAG_W)) rob0 (
        .clk(clk), .n_rst(n_rst), .alloc_en(alloc_en), .flush(flush),
        .disp_op(disp_op), .disp_rdest(disp_rdest), .disp_iaddr(disp_iaddr),
        .disp_tag(disp_tag),
        .cdb_valid(cdb_valid), .cdb_tag(cdb_tag), .cdb_data(cdb_data), .cdb_taken(cdb_taken),
        .map_busy0(map_busy0), .map_busy1(map_busy1),
        .map_tag0(map_tag0), .map_tag1(map_tag1),
        .map_data0(map_data0), .map_data1(map_data1),
        .src_rdy0(src_rdy0), .src_rdy1(src_rdy1),
        .src_tag0(src_tag0), .src_tag1(src_tag1),
        .src_data0(src_data0), .src_data1(src_data1),
        .retire_en(retire_en), .retire_valid(retire_valid),
        .retire_rdest(retire_rdest), .retire_data(retire_data), .retire_tag(retire_tag),
        .head_redirect(head_redirect), .redirect_addr(redirect_addr)
    );

    register_map #(.TAG_W(TAG_W)) map0 (
        .clk(clk), .n_rst(n_rst),
        .alloc_en(alloc_en), .disp_rdest(disp_rdest), .disp_tag(disp_tag),
        .retire_valid(retire_valid), .retire_rdest(retire_rdest),
        .retire_data(retire_data), .retire_tag(retire_tag), .flush(flush),
        .disp_rsrc0(disp_rsrc0), .disp_rsrc1(disp_rsrc1),
        .map_busy0(map_busy0), .map_busy1(map_busy1),
        .map_tag0(map_tag0), .map_tag1(map_tag1),
        .map_data0(map_data0), .map_data1(map_data1)
    );

    cdb_arbiter #(.TAG_W(TAG_W)) arb0 (
        .clk(clk), .n_rst(n_rst),
        .ex0_valid(ex0_valid), .ex0_tag(ex0_tag), .ex0_data(ex0_data),
        .ex0_taken(ex0_taken), .ex0_ready(ex0_ready),
        .ex1_valid(ex1_valid), .ex1_tag(ex1_tag), .ex1_data(ex1_data),
        .ex1_taken(ex1_taken), .ex1_ready(ex1_ready),
        .cdb_valid(cdb_valid), .cdb_tag(cdb_tag), .cdb_data(cdb_data), .cdb_taken(cdb_taken)
    );

endmodule

// ==== dv/ooo_retire_tests.svh ====
/*
 * Directed tests for the retirement core: ordering, back-pressure,
 * operand lookup, CDB arbitration and branch flush
 */

task automatic in_order_retire();
    logic [TAG_W-1:0] t [6];
    int err0;
    int ret0;
    err0 = errors;
    ret0 = retires;
    for (int i = 0; i < 6; i++) begin
        dispatch(OP_ALU, i + 1, 0, 0, t[i]);
    end
    // Youngest completes first, so nothing may leave until the oldest is done
    for (int i = 5; i >= 1; i--) begin
        complete(t[i], $urandom, 1'b0);
    end
    compare("retire count", ret0, retires);
    complete(t[0], $urandom, 1'b0);
    wait_drain();
    report_test("in-order retire", err0);
endtask

task automatic full_backpressure();
    logic [TAG_W-1:0] t [ROB_DEPTH];
    int err0;
    int ret0;
    err0 = errors;
    for (int i = 0; i < ROB_DEPTH; i++) begin
        dispatch(OP_LOAD, 8 + (i % 4), 0, 0, t[i]);
    end
    @(negedge clk);
    compare("disp_ready", 1'b0, disp_ready);
    ret0 = retires;
    complete(t[0], $urandom, 1'b0);
    do begin
        @(negedge clk);
    end while (!disp_ready);
    // Room opens only after exactly one entry has left
    @(posedge clk);
    compare("retire count", ret0 + 1, retires);
    for (int i = 1; i < ROB_DEPTH; i++) begin
        complete(t[i], $urandom, 1'b0);
    end
    wait_drain();
    report_test("full back-pressure", err0);
endtask

task automatic operand_lookup();
    logic [TAG_W-1:0] ta;
    logic [TAG_W-1:0] tblk;
    logic [TAG_W-1:0] tc;
    logic [XLEN-1:0] dc;
    int err0;
    err0 = errors;
    // Retired producer, so the committed value is read
    dispatch(OP_ALU, 10, 0, 0, ta);
    complete(ta, $urandom, 1'b0);
    wait_drain();
    @(posedge clk);
    disp_rsrc0 <= 10;
    disp_rsrc1 <= 0;
    @(negedge clk);
    compare("src_rdy0", 1'b1, src_rdy0);
    compare("src_data0", model_regs[10], src_data0);
    compare("src_rdy1", 1'b1, src_rdy1);
    compare("src_data1", '0, src_data1);
    // An older blocker keeps the second producer from retiring
    dispatch(OP_ALU, 12, 0, 0, tblk);
    dispatch(OP_ALU, 11, 0, 0, tc);
    @(posedge clk);
    disp_rsrc0 <= 12;
    disp_rsrc1 <= 11;
    @(negedge clk);
    compare("src_rdy0", 1'b0, src_rdy0);
    compare("src_tag0", tblk, src_tag0);
    compare("src_rdy1", 1'b0, src_rdy1);
    compare("src_tag1", tc, src_tag1);
    // Producer broadcasting in the same cycle as the lookup
    dc = $urandom;
    @(posedge clk);
    ex0_valid <= 1'b1;
    ex0_tag   <= tc;
    ex0_data  <= dc;
    ex0_taken <= 1'b0;
    res_model[tc] = dc;
    @(negedge clk);
    compare("src_rdy1", 1'b1, src_rdy1);
    compare("src_data1", dc, src_data1);
    @(posedge clk);
    ex0_valid <= 1'b0;
    // Done but still behind the blocker, so the ROB entry supplies it
    @(negedge clk);
    compare("src_rdy1", 1'b1, src_rdy1);
    compare("src_data1", res_model[tc], src_data1);
    complete(tblk, $urandom, 1'b0);
    wait_drain();
    report_test("operand resolution", err0);
endtask

task automatic cdb_arbitration();
    logic [TAG_W-1:0] ta;
    logic [TAG_W-1:0] tb;
    int err0;
    err0 = errors;
    dispatch(OP_ALU, 13, 0, 0, ta);
    dispatch(OP_STORE, 14, 0, 0, tb);
    @(posedge clk);
    ex0_valid <= 1'b1;
    ex0_tag   <= ta;
    ex0_data  <= $urandom;
    ex0_taken <= 1'b0;
    ex1_valid <= 1'b1;
    ex1_tag   <= tb;
    ex1_data  <= $urandom;
    ex1_taken <= 1'b0;
    @(negedge clk);
    res_model[ta] = ex0_data;
    res_model[tb] = ex1_data;
    compare("ex0_ready", 1'b1, ex0_ready);
    compare("ex1_ready", 1'b0, ex1_ready);
    @(posedge clk);
    ex0_valid <= 1'b0;
    @(negedge clk);
    compare("ex1_ready", 1'b1, ex1_ready);
    @(posedge clk);
    ex1_valid <= 1'b0;
    wait_drain();
    report_test("CDB arbitration", err0);
endtask

task automatic branch_flush();
    logic [TAG_W-1:0] tbr;
    logic [TAG_W-1:0] ty0;
    logic [TAG_W-1:0] ty1;
    logic [TAG_W-1:0] tf;
    int err0;
    int red0;
    err0 = errors;
    dispatch(OP_BRANCH, 0, 0, 0, tbr);
    dispatch(OP_ALU, 15, 0, 0, ty0);
    dispatch(OP_ALU, 16, 0, 0, ty1);
    red0 = redirects;
    complete(ty0, $urandom, 1'b0);
    complete(ty1, $urandom, 1'b0);
    // High bit set keeps the target away from any instruction address used here
    complete(tbr, 32'h8000_0000 | $urandom, 1'b1);
    while (redirects == red0) begin
        @(posedge clk);
    end
    @(negedge clk);
    compare("disp_ready", 1'b1, disp_ready);
    // Squashed producers leave their registers free with the old committed data
    dispatch(OP_ALU, 17, 15, 13, tf);
    compare("disp_tag", '0, tf);
    @(negedge clk);
    compare("src_rdy0", 1'b1, src_rdy0);
    compare("src_data0", model_regs[15], src_data0);
    compare("src_rdy1", 1'b1, src_rdy1);
    compare("src_data1", model_regs[13], src_data1);
    complete(tf, $urandom, 1'b0);
    wait_drain();
    report_test("taken-branch flush", err0);
endtask

// ==== dv/ooo_retire_tb.sv ====
/*
 * Testbench for the retirement core: clock, reset, a model of committed
 * registers and in-flight instructions, a retire monitor and the run summary
 */
module ooo_retire_tb import rob_pkg::*;;

    localparam int ROB_DEPTH = 16;
    localparam int TAG_W     = 4;
    // The five tests take roughly 500 cycles together, so this leaves about four times that
    localparam int TIMEOUT_CYCLES = 2000;

    logic clk;
    logic n_rst;
    logic disp_valid, disp_ready;
    rob_op_t disp_op;
    logic [RADDR_W-1:0] disp_rdest, disp_rsrc0, disp_rsrc1;
    logic [XLEN-1:0] disp_iaddr;
    logic [TAG_W-1:0] disp_tag;
    logic src_rdy0, src_rdy1;
    logic [TAG_W-1:0] src_tag0, src_tag1;
    logic [XLEN-1:0] src_data0, src_data1;
    logic ex0_valid, ex0_ready, ex0_taken, ex1_valid, ex1_ready, ex1_taken;
    logic [TAG_W-1:0] ex0_tag, ex1_tag;
    logic [XLEN-1:0] ex0_data, ex1_data;
    logic retire_valid;
    logic [RADDR_W-1:0] retire_rdest;
    logic [XLEN-1:0] retire_data;
    logic redirect;
    logic [XLEN-1:0] redirect_addr;

    // Reference model: committed registers, the result each tag completed with,
    // and the in-flight instructions in program order
    logic [XLEN-1:0] model_regs [NREG];
    logic [XLEN-1:0] res_model [ROB_DEPTH];
    logic [TAG_W-1:0] q_tag [$];
    int q_rdest [$];
    bit q_br [$];
    logic [XLEN-1:0] next_iaddr;

    int errors;
    int tests_run;
    int tests_failed;
    int retires;
    int redirects;
    int cycles;

    ooo_retire_top #(.ROB_DEPTH(ROB_DEPTH), .TAG_W(TAG_W)) dut0 (.*);

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles >= TIMEOUT_CYCLES) begin
            $display("Timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("ERRORS FOUND");
            $finish;
        end
    end

    function automatic void compare(input string name, input logic [XLEN-1:0] expv,
                                    input logic [XLEN-1:0] actv);
        if (expv !== actv) begin
            $display("ERROR at %0t: %s expected %h, got %h", $time, name, expv, actv);
            errors++;
        end
    endfunction

    // Retirements must come out in program order, with the data each tag completed with
    always @(negedge clk) begin
        if (n_rst === 1'b1 && retire_valid === 1'b1) begin
            if (q_tag.size() == 0) begin
                $display("ERROR at %0t: an instruction retired with nothing in flight", $time);
                errors++;
            end else begin
                compare("retire_rdest", q_rdest[0], retire_rdest);
                compare("retire_data", res_model[q_tag[0]], retire_data);
                if (q_rdest[0] != 0) begin
                    model_regs[q_rdest[0]] = res_model[q_tag[0]];
                end
                void'(q_tag.pop_front());
                void'(q_rdest.pop_front());
                void'(q_br.pop_front());
                retires++;
            end
        end
        // A redirect squashes everything, so the model drops all younger work
        if (n_rst === 1'b1 && redirect === 1'b1) begin
            redirects++;
            compare("disp_ready", 1'b0, disp_ready);
            if (q_tag.size() == 0 || !q_br[0]) begin
                $display("ERROR at %0t: redirect with no branch at the head", $time);
                errors++;
            end else begin
                compare("redirect_addr", res_model[q_tag[0]], redirect_addr);
            end
            q_tag.delete();
            q_rdest.delete();
            q_br.delete();
        end
    end

    task automatic dispatch(input rob_op_t op, input int rdest, input int rs0, input int rs1,
                            output logic [TAG_W-1:0] tag);
        @(posedge clk);
        disp_valid <= 1'b1;
        disp_op    <= op;
        disp_rdest <= rdest;
        disp_rsrc0 <= rs0;
        disp_rsrc1 <= rs1;
        disp_iaddr <= next_iaddr;
        @(negedge clk);
        while (!disp_ready) begin
            @(negedge clk);
        end
        tag = disp_tag;
        // The transfer happens on this edge
        @(posedge clk);
        disp_valid <= 1'b0;
        q_tag.push_back(tag);
        q_rdest.push_back(rdest);
        q_br.push_back(op == OP_BRANCH);
        next_iaddr = next_iaddr + 4;
    endtask

    // ex0 is never stalled, so one cycle of valid is one transfer
    task automatic complete(input logic [TAG_W-1:0] tag, input logic [XLEN-1:0] data,
                            input logic taken);
        @(posedge clk);
        ex0_valid <= 1'b1;
        ex0_tag   <= tag;
        ex0_data  <= data;
        ex0_taken <= taken;
        res_model[tag] = data;
        @(posedge clk);
        ex0_valid <= 1'b0;
    endtask

    task automatic wait_drain();
        while (q_tag.size() != 0) begin
            @(posedge clk);
        end
    endtask

    task automatic report_test(input string name, input int errors_before);
        tests_run++;
        if (errors == errors_before) begin
            $display("Test %s passed", name);
        end else begin
            tests_failed++;
            $display("Test %s failed with %0d errors", name, errors - errors_before);
        end
    endtask

    `include "ooo_retire_tests.svh"

    initial begin
        void'($urandom(59));
        n_rst = 1'b0;
        disp_valid = 1'b0;
        disp_op = OP_ALU;
        disp_rdest = '0;
        disp_rsrc0 = '0;
        disp_rsrc1 = '0;
        disp_iaddr = '0;
        ex0_valid = 1'b0;
        ex0_tag = '0;
        ex0_data = '0;
        ex0_taken = 1'b0;
        ex1_valid = 1'b0;
        ex1_tag = '0;
        ex1_data = '0;
        ex1_taken = 1'b0;
        next_iaddr = 32'h0000_1000;
        for (int i = 0; i < NREG; i++) begin
            model_regs[i] = '0;
        end
        repeat (10) @(posedge clk);
        n_rst <= 1'b1;
        in_order_retire();
        full_backpressure();
        operand_lookup();
        cdb_arbitration();
        branch_flush();
        $display("Tests run %0d, failed %0d, errors %0d", tests_run, tests_failed, errors);
        if (errors == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule

// ==== ooo_retire.f ====
+incdir+dv
common/rob_pkg.sv
rob/reorder_buffer.sv
hw/register_map.sv
hw/cdb_arbiter.sv
hw/dispatch_ctrl.sv
hw/ooo_retire_top.sv
dv/ooo_retire_tb.sv
